//--- src/decoder_pkg.sv
`default_nettype none

package decoder_pkg;

    // lattice size in the two code dimensions
    localparam int code_distance_x = 3;
    localparam int code_distance_z = 3;

    // syndrome rounds stacked as the third dimension
    localparam int measurement_rounds = 3;

    localparam int pu_count = code_distance_x * code_distance_z * measurement_rounds;

    // every unit has x-, x+, z-, z+, round-, round+ slots
    localparam int neighbor_count = 6;

    localparam int coord_width = 2;

    // {round, x, z}
    localparam int address_width = 3 * coord_width;

    // matching graph weights per dimension
    localparam int weight_x = 2;
    localparam int weight_z = 1;
    localparam int weight_ud = 1;

    // growth steps needed per link are two per unit of weight
    localparam int cost_x = 2 * weight_x;
    localparam int cost_z = 2 * weight_z;
    localparam int cost_ud = 2 * weight_ud;

    // holds the largest cost
    localparam int growth_width = 3;

    typedef logic [address_width-1:0] address_t;
    typedef logic [growth_width-1:0] growth_t;
    typedef logic [pu_count-1:0] pu_vec_t;

    typedef enum logic [1:0] {
        stage_idle,
        stage_measurement_loading,
        stage_grow,
        stage_merge
    } stage_t;

    // what a link sees of one endpoint
    typedef struct packed {
        address_t root;
        logic increase;
    } link_side_t;

    // unit n = round * 9 + x * 3 + z sits at index n
    typedef address_t [pu_count-1:0] root_array_t;

endpackage

`default_nettype wire

//--- src/neighbor_link.sv
`timescale 1ns/1ps
`default_nettype none

module neighbor_link import decoder_pkg::*; #(
    parameter growth_t length = growth_t'(cost_z)
) (
    input wire clk,
    input wire reset,
    input wire stage_t stage,
    input wire link_side_t a,
    input wire link_side_t b,
    output logic fully_grown,
    output address_t a_root_out,
    output address_t b_root_out
);

    growth_t count;
    growth_t next_count;
    logic [growth_width:0] step_sum;

    // both endpoints grow the same edge up to its cost
    always_comb begin
        step_sum = {1'b0, count}
            + {{growth_width{1'b0}}, a.increase}
            + {{growth_width{1'b0}}, b.increase};
        if (step_sum >= {1'b0, length}) begin
            next_count = length;
        end else begin
            next_count = step_sum[growth_width-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else begin
            case (stage)
                stage_measurement_loading: count <= '0;
                stage_grow: count <= next_count;
                default: begin
                end
            endcase
        end
    end

    assign fully_grown = (count == length);

    // roots cross the edge in both directions
    assign a_root_out = a.root;
    assign b_root_out = b.root;

    count_bounded_a: assert property (
        @(posedge clk) disable iff (reset)
        count <= length
    );

endmodule

`default_nettype wire

//--- src/processing_unit.sv
`timescale 1ns/1ps
`default_nettype none

module processing_unit import decoder_pkg::*; (
    input wire clk,
    input wire reset,
    input wire stage_t stage,
    input wire init_is_error_syndrome,
    input wire address_t self_address,
    input wire [neighbor_count-1:0] neighbor_is_fully_grown,
    input wire address_t [neighbor_count-1:0] neighbor_roots,
    output stage_t stage_q,
    output link_side_t side,
    output address_t root,
    output logic busy
);

    logic defect;
    address_t merged_root;

    // smallest root visible across fully grown links
    always_comb begin
        merged_root = root;
        for (int i = 0; i < neighbor_count; i++) begin
            if (neighbor_is_fully_grown[i] && (neighbor_roots[i] < merged_root)) begin
                merged_root = neighbor_roots[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_q <= stage_idle;
            defect <= 1'b0;
            root <= self_address;
            busy <= 1'b0;
        end else begin
            // one cycle of pipeline delay on the stage
            stage_q <= stage;
            busy <= 1'b0;
            case (stage_q)
                stage_measurement_loading: begin
                    defect <= init_is_error_syndrome;
                    root <= self_address;
                end
                stage_merge: begin
                    root <= merged_root;
                    busy <= (merged_root != root);
                end
                default: begin
                end
            endcase
        end
    end

    // defect units push growth into every link they touch
    assign side = link_side_t'{root: root, increase: defect};

    // roots only ever flood downward from the site's own address
    root_bounded_a: assert property (
        @(posedge clk) disable iff (reset)
        (stage_q != stage_measurement_loading) |-> (root <= self_address)
    );

endmodule

`default_nettype wire

//--- src/decoder_mesh.sv
`timescale 1ns/1ps
`default_nettype none

module decoder_mesh import decoder_pkg::*; (
    input wire clk,
    input wire reset,
    input wire stage_t stage,
    input wire pu_vec_t is_error_syndromes,
    output root_array_t roots,
    output logic has_message_flying
);

    // x, z and round
    localparam int dims = 3;

    stage_t stage_q [pu_count];
    link_side_t side [pu_count];
    address_t unit_root [pu_count];
    logic unit_busy [pu_count];
    pu_vec_t busy_q;

    wire [neighbor_count-1:0] nb_grown [pu_count];
    wire address_t [neighbor_count-1:0] nb_roots [pu_count];

    // outputs of the positive-direction link owned by each unit
    wire grown [dims][pu_count];
    wire address_t a_root [dims][pu_count];
    wire address_t b_root [dims][pu_count];

    for (genvar r = 0; r < measurement_rounds; r++) begin : g_round
        for (genvar x = 0; x < code_distance_x; x++) begin : g_x
            for (genvar z = 0; z < code_distance_z; z++) begin : g_z
                localparam int n = r * code_distance_x * code_distance_z
                    + x * code_distance_z + z;
                localparam address_t self_address = address_t'(
                    (r << (2 * coord_width)) | (x << coord_width) | z);

                processing_unit unit_i (
                    .clk(clk),
                    .reset(reset),
                    .stage(stage),
                    .init_is_error_syndrome(is_error_syndromes[n]),
                    .self_address(self_address),
                    .neighbor_is_fully_grown(nb_grown[n]),
                    .neighbor_roots(nb_roots[n]),
                    .stage_q(stage_q[n]),
                    .side(side[n]),
                    .root(unit_root[n]),
                    .busy(unit_busy[n])
                );

                for (genvar d = 0; d < dims; d++) begin : g_dim
                    localparam int coord = (d == 0) ? x : ((d == 1) ? z : r);
                    localparam int size = (d == 0) ? code_distance_x
                        : ((d == 1) ? code_distance_z : measurement_rounds);
                    localparam int stride = (d == 0) ? code_distance_z
                        : ((d == 1) ? 1 : code_distance_x * code_distance_z);
                    localparam growth_t length = (d == 0) ? growth_t'(cost_x)
                        : ((d == 1) ? growth_t'(cost_z) : growth_t'(cost_ud));

                    // the lower-index unit is side a and supplies the stage
                    if (coord < size - 1) begin : g_link
                        neighbor_link #(
                            .length(length)
                        ) link_i (
                            .clk(clk),
                            .reset(reset),
                            .stage(stage_q[n]),
                            .a(side[n]),
                            .b(side[n + stride]),
                            .fully_grown(grown[d][n]),
                            .a_root_out(a_root[d][n]),
                            .b_root_out(b_root[d][n])
                        );
                    end else begin : g_edge
                        assign grown[d][n] = 1'b0;
                        assign a_root[d][n] = '1;
                        assign b_root[d][n] = '1;
                    end

                    // plus slot is tied inactive by g_edge at the lattice edge
                    assign nb_grown[n][2 * d + 1] = grown[d][n];
                    assign nb_roots[n][2 * d + 1] = b_root[d][n];

                    if (coord > 0) begin : g_minus
                        assign nb_grown[n][2 * d] = grown[d][n - stride];
                        assign nb_roots[n][2 * d] = a_root[d][n - stride];
                    end else begin : g_no_minus
                        assign nb_grown[n][2 * d] = 1'b0;
                        assign nb_roots[n][2 * d] = '1;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int n = 0; n < pu_count; n++) begin
            roots[n] = unit_root[n];
        end
    end

    // second register stage on the busy flags
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= '0;
        end else begin
            for (int n = 0; n < pu_count; n++) begin
                busy_q[n] <= unit_busy[n];
            end
        end
    end

    assign has_message_flying = |busy_q;

endmodule

`default_nettype wire

//--- testbench/decoder_model.svh
`ifndef DECODER_MODEL_SVH
`define DECODER_MODEL_SVH

// taps of x^32 + x^22 + x^2 + x + 1 with the shift toward the msb
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
endfunction

// site identity {round, x, z} of unit n
function automatic address_t site_address(input int n);
    logic [coord_width-1:0] r;
    logic [coord_width-1:0] x;
    logic [coord_width-1:0] z;
    r = coord_width'(n / (code_distance_x * code_distance_z));
    x = coord_width'((n / code_distance_z) % code_distance_x);
    z = coord_width'(n % code_distance_z);
    return {r, x, z};
endfunction

// each defect endpoint adds one step per grow cycle
function automatic bit link_grown(input bit defect_a, input bit defect_b,
                                  input int grow_cycles, input int cost);
    int steps;
    steps = (int'(defect_a) + int'(defect_b)) * grow_cycles;
    return steps >= cost;
endfunction

function automatic root_array_t expected_roots(input pu_vec_t syndromes,
                                               input int grow_cycles);
    root_array_t model;
    bit edge_grown [3][pu_count];
    int coord [3];
    int extent [3];
    int stride [3];
    int cost [3];
    bit changed;
    int passes;
    int other;
    // dimension 0 is x, 1 is z, 2 is round
    extent[0] = code_distance_x;
    extent[1] = code_distance_z;
    extent[2] = measurement_rounds;
    stride[0] = code_distance_z;
    stride[1] = 1;
    stride[2] = code_distance_x * code_distance_z;
    cost[0] = cost_x;
    cost[1] = cost_z;
    cost[2] = cost_ud;
    for (int n = 0; n < pu_count; n++) begin
        model[n] = site_address(n);
        coord[0] = (n / code_distance_z) % code_distance_x;
        coord[1] = n % code_distance_z;
        coord[2] = n / (code_distance_x * code_distance_z);
        for (int d = 0; d < 3; d++) begin
            edge_grown[d][n] = 1'b0;
            if (coord[d] < extent[d] - 1) begin
                edge_grown[d][n] = link_grown(syndromes[n], syndromes[n + stride[d]],
                    grow_cycles, cost[d]);
            end
        end
    end
    changed = 1'b1;
    passes = 0;
    // smallest address floods across grown edges
    while (changed && (passes < pu_count)) begin
        changed = 1'b0;
        passes++;
        for (int n = 0; n < pu_count; n++) begin
            for (int d = 0; d < 3; d++) begin
                if (edge_grown[d][n]) begin
                    other = n + stride[d];
                    if (model[other] < model[n]) begin
                        model[n] = model[other];
                        changed = 1'b1;
                    end else if (model[n] < model[other]) begin
                        model[other] = model[n];
                        changed = 1'b1;
                    end
                end
            end
        end
    end
    return model;
endfunction

`endif

//--- testbench/tb_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decoder import decoder_pkg::*; ();

    localparam int flying_timeout = 200;
    localparam int compare_timeout = 4;
    // sample at least three cycles into merge
    localparam int merge_settle = 4;
    localparam int random_runs = 20;

    logic clk;
    logic reset;
    stage_t stage;
    pu_vec_t is_error_syndromes;
    root_array_t roots;
    logic has_message_flying;

    logic [31:0] lfsr_state;
    root_array_t expected;
    string test_name;
    event compare_request;
    bit compare_pending;

    `include "decoder_model.svh"

    decoder_mesh dut_i (
        .clk(clk),
        .reset(reset),
        .stage(stage),
        .is_error_syndromes(is_error_syndromes),
        .roots(roots),
        .has_message_flying(has_message_flying)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // one LFSR step per bit taken
    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic request_compare(input string name, input root_array_t model);
        int waited;
        test_name = name;
        expected = model;
        compare_pending = 1'b1;
        -> compare_request;
        waited = 0;
        while (compare_pending) begin
            if (waited >= compare_timeout) begin
                $display("Timeout: the root comparison never finished in test %s", name);
                $display("Result: FAILED");
                $fatal(1, "comparison stalled");
            end
            @(negedge clk);
            waited++;
        end
    endtask

    // load, grow for grow_cycles, then merge until the mesh goes quiet
    task automatic run_decode(input string name, input pu_vec_t syndromes,
                              input int grow_cycles);
        int waited;
        @(negedge clk);
        stage = stage_measurement_loading;
        is_error_syndromes = syndromes;
        for (int i = 0; i < grow_cycles; i++) begin
            @(negedge clk);
            stage = stage_grow;
        end
        @(negedge clk);
        stage = stage_merge;
        repeat (merge_settle) @(negedge clk);
        waited = 0;
        while (has_message_flying) begin
            if (waited >= flying_timeout) begin
                $display("Timeout: has_message_flying never cleared in test %s", name);
                $display("Result: FAILED");
                $fatal(1, "flying flag stuck high");
            end
            @(negedge clk);
            waited++;
        end
        request_compare(name, expected_roots(syndromes, grow_cycles));
    endtask

    initial begin
        forever begin
            @(compare_request);
            for (int i = 0; i < pu_count; i++) begin
                assert (roots[i] == expected[i]) else begin
                    $display("Mismatch in test %s: unit %0d expected root %h, actual root %h",
                        test_name, i, expected[i], roots[i]);
                    $display("Result: FAILED");
                    $fatal(1, "root check failed");
                end
            end
            compare_pending = 1'b0;
        end
    end

    initial begin
        pu_vec_t syndromes;
        logic [31:0] bits;
        int grow_cycles;
        reset = 1'b1;
        stage = stage_idle;
        is_error_syndromes = '0;
        compare_pending = 1'b0;
        lfsr_state = 32'h115a_d814;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        assert (!has_message_flying) else begin
            $display("Mismatch in test reset: has_message_flying expected 0, actual %b",
                has_message_flying);
            $display("Result: FAILED");
            $fatal(1, "flying flag high after reset");
        end
        request_compare("reset", expected_roots('0, 0));

        run_decode("no_defects_n0", '0, 0);
        run_decode("no_defects_n3", '0, 3);

        // units 13 and 14 differ only in z
        syndromes = '0;
        syndromes[13] = 1'b1;
        syndromes[14] = 1'b1;
        run_decode("z_pair", syndromes, 1);

        // center site grows its z and round links but not its x links
        syndromes = '0;
        syndromes[13] = 1'b1;
        run_decode("single_defect", syndromes, 2);

        for (int run = 0; run < random_runs; run++) begin
            draw_bits(pu_count, bits);
            syndromes = pu_vec_t'(bits);
            draw_bits(2, bits);
            grow_cycles = int'(bits[1:0]);
            run_decode($sformatf("random_%0d", run), syndromes, grow_cycles);
        end

        run_decode("reload_full", '1, 3);
        run_decode("reload_clear", '0, 3);

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+testbench
src/decoder_pkg.sv
src/neighbor_link.sv
src/processing_unit.sv
src/decoder_mesh.sv
testbench/tb_decoder.sv

//--- run.sh
#!/bin/sh
# build and run the decoder testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module tb_decoder \
    -f all.f \
    -Mdir obj_dir

# the log decides the result
./obj_dir/Vtb_decoder > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
